// File: design/tcb_macros.svh
`ifndef TCB_MACROS_SVH
`define TCB_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////////////////////

// byte address width
`define TCB_ADR_W 16
// data width
`define TCB_DAT_W 32
// one enable per data byte
`define TCB_BEN_W 4

////////////////////////////////////////////////////////////////////////////
// system sizes
////////////////////////////////////////////////////////////////////////////

// memory depth in words
`define TCB_MEM_WORDS 256
// subordinate ports behind the demultiplexer
`define TCB_IFN 2

`endif

// File: design/tcb_pkg.sv
`include "tcb_macros.svh"

package tcb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  // request command
  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } tcb_cmd_t;

  // response status
  typedef enum logic {
    sts_ok  = 1'b0,
    sts_err = 1'b1
  } tcb_sts_t;

  ////////////////////////////////////////////////////////////////////////////
  // bus payloads
  ////////////////////////////////////////////////////////////////////////////

  // request held stable until rdy
  typedef struct packed {
    tcb_cmd_t               cmd;
    logic [`TCB_ADR_W-1:0]  adr;
    logic [`TCB_BEN_W-1:0]  ben;
    logic [`TCB_DAT_W-1:0]  wdt;
  } tcb_req_t;

  // response valid one cycle after transfer
  typedef struct packed {
    logic [`TCB_DAT_W-1:0]  rdt;
    tcb_sts_t               sts;
  } tcb_rsp_t;

endpackage

// File: design/tcb_map_pkg.sv
`include "tcb_macros.svh"

package tcb_map_pkg;

  // decoded address regions
  typedef enum logic [1:0] {
    region_mem  = 2'd0,
    region_regs = 2'd1,
    region_none = 2'd2
  } tcb_region_t;

  // word offsets inside the register block
  typedef enum logic [1:0] {
    reg_id      = 2'd0,
    reg_scratch = 2'd1,
    reg_count   = 2'd2,
    reg_ctrl    = 2'd3
  } tcb_reg_ofs_t;

  // memory at 0x0000 sized by the word count
  localparam logic [`TCB_ADR_W-1:0] MEM_BASE  = 'h0000;
  localparam logic [`TCB_ADR_W-1:0] MEM_MASK  = ~`TCB_ADR_W'(`TCB_MEM_WORDS * 4 - 1);

  // four registers at 0x1000
  localparam logic [`TCB_ADR_W-1:0] REGS_BASE = 'h1000;
  localparam logic [`TCB_ADR_W-1:0] REGS_MASK = ~`TCB_ADR_W'('h0F);

  // fixed identification word
  localparam logic [`TCB_DAT_W-1:0] REGS_ID_VALUE = 32'h7CB0_0001;

endpackage

// File: design/tcb_decoder.sv
`include "tcb_macros.svh"

module tcb_decoder (
  input  logic                          sub,
  input  logic                          rst_n,
  // manager side
  input  logic                          vld,
  input  tcb_pkg::tcb_req_t             req,
  output logic                          rdy,
  output tcb_pkg::tcb_rsp_t             rsp,
  // toward the demultiplexer
  output logic                          dmx_vld,
  input  logic                          dmx_rdy,
  input  tcb_pkg::tcb_rsp_t             dmx_rsp,
  output logic [$clog2(`TCB_IFN)-1:0]   sel
);

  import tcb_pkg::*;
  import tcb_map_pkg::*;

  localparam int unsigned SEL_W = $clog2(`TCB_IFN);

  tcb_region_t region;
  // unmapped access seen last cycle
  logic        err;

  ////////////////////////////////////////////////////////////////////////////
  // region decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if ((req.adr & MEM_MASK) == MEM_BASE)
      region = region_mem;
    else if ((req.adr & REGS_MASK) == REGS_BASE)
      region = region_regs;
    else
      region = region_none;
  end

  // port 1 is the register block and everything else goes to memory
  assign sel = (region == region_regs) ? SEL_W'(1) : SEL_W'(0);

  // unmapped requests never leave the decoder
  assign dmx_vld = vld && (region != region_none);
  // accepted at once when nobody else owns the address
  assign rdy = (region == region_none) ? 1'b1 : dmx_rdy;

  ////////////////////////////////////////////////////////////////////////////
  // error responder
  ////////////////////////////////////////////////////////////////////////////

  // rdy is high for region_none so vld alone marks the transfer
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      err <= 1'b0;
    end else begin
      err <= vld && (region == region_none);
    end
  end

  // own error answer wins over the routed one
  assign rsp = err ? tcb_rsp_t'{rdt: '0, sts: sts_err} : dmx_rsp;

endmodule

// File: design/tcb_demultiplexer.sv
`include "tcb_macros.svh"

module tcb_demultiplexer #(
  parameter  int unsigned IFN = `TCB_IFN,
  localparam int unsigned IFL = $clog2(IFN)
) (
  input  logic              sub,
  input  logic              rst_n,
  // port select for the current request
  input  logic [IFL-1:0]    sel,
  // upstream side
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp,
  // one manager port per subordinate
  output logic              man_vld [IFN],
  output tcb_pkg::tcb_req_t man_req [IFN],
  input  logic              man_rdy [IFN],
  input  tcb_pkg::tcb_rsp_t man_rsp [IFN]
);

  import tcb_pkg::*;

  // port that owes the next response
  logic [IFL-1:0] rsp_sel;

  ////////////////////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < IFN; i++) begin : g_port
    // only the selected port sees vld
    assign man_vld[i] = (sel == IFL'(i)) ? vld : 1'b0;
    // payload fans out everywhere
    assign man_req[i] = req;
  end

  // handshake from the port being addressed now
  assign rdy = man_rdy[sel];

  ////////////////////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////////////////////

  // remember the port at each transfer
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rsp_sel <= '0;
    end else if (vld && rdy) begin
      rsp_sel <= sel;
    end
  end

  // a new request may already be routed elsewhere
  assign rsp = man_rsp[rsp_sel];

endmodule

// File: design/tcb_sram.sv
`include "tcb_macros.svh"

module tcb_sram (
  input  logic              sub,
  input  logic              rst_n,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  localparam int unsigned IDX_W = $clog2(`TCB_MEM_WORDS);

  logic [`TCB_DAT_W-1:0] mem [`TCB_MEM_WORDS];
  logic [IDX_W-1:0]      idx;
  logic                  trn;
  logic [`TCB_DAT_W-1:0] rdt;

  // never stalls
  assign rdy = 1'b1;
  assign trn = vld && rdy;

  // word index with the byte offset dropped
  assign idx = req.adr[IDX_W+1:2];

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // byte lanes written only where ben is set
  always_ff @(posedge sub) begin
    if (trn && (req.cmd == cmd_write)) begin
      for (int b = 0; b < `TCB_BEN_W; b++) begin
        if (req.ben[b])
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // read data for next cycle while writes answer zero
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rdt <= '0;
    end else if (trn) begin
      rdt <= (req.cmd == cmd_read) ? mem[idx] : '0;
    end
  end

  // memory cannot fail
  assign rsp.rdt = rdt;
  assign rsp.sts = sts_ok;

endmodule

// File: design/tcb_regs.sv
`include "tcb_macros.svh"

module tcb_regs (
  input  logic              sub,
  input  logic              rst_n,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;
  import tcb_map_pkg::*;

  logic                  wt;
  logic                  trn;
  tcb_reg_ofs_t          ofs;
  logic                  wr_err;
  logic [`TCB_DAT_W-1:0] rd_dat;
  // register file
  logic [`TCB_DAT_W-1:0] scratch;
  logic [`TCB_DAT_W-1:0] count;
  logic [7:0]            ctrl;
  // response
  logic [`TCB_DAT_W-1:0] rdt;
  tcb_sts_t              sts;

  ////////////////////////////////////////////////////////////////////////////
  // wait state
  ////////////////////////////////////////////////////////////////////////////

  // low on the first vld cycle and high on the second
  assign rdy = wt;
  assign trn = vld && rdy;

  assign ofs = tcb_reg_ofs_t'(req.adr[3:2]);
  // id and count are read only
  assign wr_err = (req.cmd == cmd_write) && ((ofs == reg_id) || (ofs == reg_count));

  // read mux where count already includes this access
  always_comb begin
    rd_dat = '0;
    case (ofs)
      reg_id:      rd_dat = REGS_ID_VALUE;
      reg_scratch: rd_dat = scratch;
      reg_count:   rd_dat = count + 1'b1;
      reg_ctrl:    rd_dat = `TCB_DAT_W'(ctrl);
      default:     rd_dat = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // register updates
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      wt      <= 1'b0;
      scratch <= '0;
      count   <= '0;
      ctrl    <= '0;
      sts     <= sts_ok;
    end else begin
      // drops again right after the transfer
      wt <= vld && !wt;
      if (trn) begin
        // every accepted access including failed writes
        count <= count + 1'b1;
        sts   <= wr_err ? sts_err : sts_ok;
        if (req.cmd == cmd_write) begin
          if (ofs == reg_scratch) begin
            for (int b = 0; b < `TCB_BEN_W; b++) begin
              if (req.ben[b])
                scratch[8*b +: 8] <= req.wdt[8*b +: 8];
            end
          end
          // only the low byte exists
          if ((ofs == reg_ctrl) && req.ben[0])
            ctrl <= req.wdt[7:0];
        end
      end
    end
  end

  // write responses carry zero data
  always_ff @(posedge sub) begin
    if (trn)
      rdt <= (req.cmd == cmd_read) ? rd_dat : '0;
  end

  assign rsp.rdt = rdt;
  assign rsp.sts = sts;

endmodule

// File: design/tcb_subsystem.sv
`include "tcb_macros.svh"

module tcb_subsystem (
  input  logic              sub,
  input  logic              rst_n,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  localparam int unsigned IFL = $clog2(`TCB_IFN);

  ////////////////////////////////////////////////////////////////////////////
  // interconnect wiring
  ////////////////////////////////////////////////////////////////////////////

  // decoder to demultiplexer
  logic           dmx_vld;
  logic           dmx_rdy;
  tcb_rsp_t       dmx_rsp;
  logic [IFL-1:0] sel;
  // demultiplexer to subordinates with port 0 memory and port 1 registers
  logic           man_vld [`TCB_IFN];
  tcb_req_t       man_req [`TCB_IFN];
  logic           man_rdy [`TCB_IFN];
  tcb_rsp_t       man_rsp [`TCB_IFN];

  // decode with an error answer for holes in the map
  tcb_decoder u_dec (
    .sub     (sub),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rdy     (rdy),
    .rsp     (rsp),
    .dmx_vld (dmx_vld),
    .dmx_rdy (dmx_rdy),
    .dmx_rsp (dmx_rsp),
    .sel     (sel)
  );

  // route
  tcb_demultiplexer #(.IFN(`TCB_IFN)) u_dmx (
    .sub     (sub),
    .rst_n   (rst_n),
    .sel     (sel),
    .vld     (dmx_vld),
    .req     (req),
    .rdy     (dmx_rdy),
    .rsp     (dmx_rsp),
    .man_vld (man_vld),
    .man_req (man_req),
    .man_rdy (man_rdy),
    .man_rsp (man_rsp)
  );

  // execute
  tcb_sram u_mem (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (man_vld[0]),
    .req   (man_req[0]),
    .rdy   (man_rdy[0]),
    .rsp   (man_rsp[0])
  );

  tcb_regs u_regs (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (man_vld[1]),
    .req   (man_req[1]),
    .rdy   (man_rdy[1]),
    .rsp   (man_rsp[1])
  );

endmodule

// File: tests/tcb_subsystem_asserts.sv
`include "tcb_macros.svh"

module tcb_subsystem_asserts (
  input  logic              sub,
  input  logic              rst_n,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  input  logic              rdy,
  input  tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;
  import tcb_map_pkg::*;

  logic                  trn;
  logic                  is_mem;
  logic                  is_regs;
  // next vld cycle starts a new request
  logic                  first;
  logic [7:0]            widx;
  tcb_reg_ofs_t          ofs;
  // shadow models where the mask marks bytes written so far
  logic [`TCB_DAT_W-1:0] sh_mem [`TCB_MEM_WORDS];
  logic [`TCB_DAT_W-1:0] sh_msk [`TCB_MEM_WORDS];
  logic [`TCB_DAT_W-1:0] sh_scratch;
  logic [7:0]            sh_ctrl;
  logic [`TCB_DAT_W-1:0] reg_trn;
  // expected response for the cycle after a transfer
  logic                  exp_vld;
  logic [`TCB_DAT_W-1:0] exp_rdt;
  logic [`TCB_DAT_W-1:0] exp_msk;
  tcb_sts_t              exp_sts;
  int                    errors = 0;

  assign trn     = vld && rdy;
  // memory 0x0000 to 0x03ff and registers 0x1000 to 0x100f
  assign is_mem  = req.adr < 16'h0400;
  assign is_regs = req.adr[15:4] == 12'h100;
  assign widx    = req.adr[9:2];
  assign ofs     = tcb_reg_ofs_t'(req.adr[3:2]);

  ////////////////////////////////////////////////////////////////////////////
  // shadow update and expected response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      first      <= 1'b1;
      exp_vld    <= 1'b0;
      exp_rdt    <= '0;
      exp_msk    <= '0;
      exp_sts    <= sts_ok;
      sh_scratch <= '0;
      sh_ctrl    <= '0;
      reg_trn    <= '0;
      for (int i = 0; i < `TCB_MEM_WORDS; i++)
        sh_msk[i] <= '0;
    end else begin
      first   <= !vld || rdy;
      exp_vld <= trn;
      if (trn) begin
        // writes that succeed leave rdt unchecked
        exp_sts <= sts_ok;
        exp_rdt <= '0;
        exp_msk <= '0;
        if (is_mem) begin
          if (req.cmd == cmd_read) begin
            exp_rdt <= sh_mem[widx];
            exp_msk <= sh_msk[widx];
          end else begin
            for (int b = 0; b < `TCB_BEN_W; b++) begin
              if (req.ben[b]) begin
                sh_mem[widx][8*b +: 8] <= req.wdt[8*b +: 8];
                sh_msk[widx][8*b +: 8] <= 8'hff;
              end
            end
          end
        end else if (is_regs) begin
          // failed writes still count as accepted
          reg_trn <= reg_trn + 32'd1;
          if (req.cmd == cmd_read)
            exp_msk <= '1;
          case (ofs)
            reg_id: begin
              exp_rdt <= (req.cmd == cmd_read) ? 32'h7CB0_0001 : 32'd0;
              if (req.cmd == cmd_write) begin
                exp_sts <= sts_err;
                exp_msk <= '1;
              end
            end
            reg_scratch: begin
              exp_rdt <= sh_scratch;
              for (int b = 0; b < `TCB_BEN_W; b++) begin
                if ((req.cmd == cmd_write) && req.ben[b])
                  sh_scratch[8*b +: 8] <= req.wdt[8*b +: 8];
              end
            end
            reg_count: begin
              exp_rdt <= (req.cmd == cmd_read) ? reg_trn + 32'd1 : 32'd0;
              if (req.cmd == cmd_write) begin
                exp_sts <= sts_err;
                exp_msk <= '1;
              end
            end
            default: begin
              exp_rdt <= {24'd0, sh_ctrl};
              if ((req.cmd == cmd_write) && req.ben[0])
                sh_ctrl <= req.wdt[7:0];
            end
          endcase
        end else begin
          // hole in the map
          exp_sts <= sts_err;
          exp_msk <= '1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////////////////////

  // exactly one response one cycle after each transfer
  a_rsp: assert property (@(posedge sub) disable iff (!rst_n)
    exp_vld |-> (rsp.sts == exp_sts) && (((rsp.rdt ^ exp_rdt) & exp_msk) == '0))
  else begin
    $error("error %0t: response %h sts %0d, expected %h sts %0d", $time,
           $sampled(rsp.rdt), $sampled(rsp.sts),
           $sampled(exp_rdt), $sampled(exp_sts));
    errors++;
  end

  // memory never stalls
  a_mem_rdy: assert property (@(posedge sub) disable iff (!rst_n)
    vld && is_mem |-> rdy)
  else begin
    $error("error %0t: memory access saw rdy low", $time);
    errors++;
  end

  // unmapped addresses are taken at once
  a_none_rdy: assert property (@(posedge sub) disable iff (!rst_n)
    vld && !is_mem && !is_regs |-> rdy)
  else begin
    $error("error %0t: unmapped access saw rdy low", $time);
    errors++;
  end

  // register wait state on the first cycle only
  a_reg_wait: assert property (@(posedge sub) disable iff (!rst_n)
    vld && is_regs && first |-> !rdy)
  else begin
    $error("error %0t: register access without wait state", $time);
    errors++;
  end

  a_reg_go: assert property (@(posedge sub) disable iff (!rst_n)
    vld && is_regs && !first |-> rdy)
  else begin
    $error("error %0t: register access stalled past one cycle", $time);
    errors++;
  end

endmodule

// File: tests/tcb_subsystem_tb.sv
`include "tcb_macros.svh"

module tcb_subsystem_tb;

  import tcb_pkg::*;

  localparam int PERIOD = 40;
  localparam int N_FILL = 16;
  localparam int N_RAND = 48;
  // fill, random mix, top word, registers, unmapped, region switching
  localparam int N_ACC  = N_FILL + N_RAND + 2 + 12 + 4 + 6;

  logic     sub;
  logic     rst_n;
  logic     vld;
  tcb_req_t req;
  logic     rdy;
  tcb_rsp_t rsp;
  int       seed = 88;

  bind tcb_subsystem tcb_subsystem_asserts u_chk (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp)
  );

  tcb_subsystem UUT (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (vld),
    .req   (req),
    .rdy   (rdy),
    .rsp   (rsp)
  );

  always #(PERIOD/2) sub = ~sub;

  ////////////////////////////////////////////////////////////////////////////
  // bus driver
  ////////////////////////////////////////////////////////////////////////////

  // request held until a rising edge with rdy high
  task automatic access(input tcb_cmd_t cmd, input logic [15:0] adr,
                        input logic [3:0] ben, input logic [31:0] wdt);
    logic done;
    @(negedge sub);
    vld     <= 1'b1;
    req.cmd <= cmd;
    req.adr <= adr;
    req.ben <= ben;
    req.wdt <= wdt;
    done = 1'b0;
    // rdy read before the edge updates the wait flag
    while (!done) begin
      @(posedge sub);
      done = rdy;
    end
  endtask

  task automatic idle(input int cycles);
    @(negedge sub);
    vld <= 1'b0;
    repeat (cycles) @(negedge sub);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog and failure monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #((N_ACC * 3 + 20) * PERIOD);
    $display("test failed");
    $fatal(1, "watchdog expired, the bus handshake hung");
  end

  always @(negedge sub) begin
    if (UUT.u_chk.errors != 0) begin
      $display("test failed");
      $fatal(1, "bound checker reported a failing assertion");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] dat;
    sub   = 1'b0;
    rst_n = 1'b0;
    vld   = 1'b0;
    req   = '0;
    repeat (3) @(negedge sub);
    rst_n <= 1'b1;

    // partial fill of the first words with word 0 written whole
    for (int i = 0; i < N_FILL; i++) begin
      rnd = $random(seed);
      dat = $random(seed);
      access(cmd_write, 16'(i * 4), (i == 0) ? 4'hf : rnd[3:0], dat);
    end
    // back to back reads and writes
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      dat = $random(seed);
      access(rnd[8] ? cmd_write : cmd_read, {10'd0, rnd[7:4], 2'b00}, rnd[3:0], dat);
    end
    // last word of memory
    dat = $random(seed);
    access(cmd_write, 16'h03fc, 4'hf, dat);
    access(cmd_read,  16'h03fc, 4'hf, 32'd0);

    // register block
    access(cmd_read,  16'h1000, 4'hf, 32'd0);
    access(cmd_write, 16'h1004, 4'hf, 32'h1234_5678);
    access(cmd_read,  16'h1004, 4'hf, 32'd0);
    dat = $random(seed);
    access(cmd_write, 16'h1004, 4'b0101, dat);
    access(cmd_read,  16'h1004, 4'hf, 32'd0);
    access(cmd_write, 16'h100c, 4'hf, 32'hdead_beef);
    access(cmd_read,  16'h100c, 4'hf, 32'd0);
    access(cmd_read,  16'h1008, 4'hf, 32'd0);
    // read only registers refuse writes
    access(cmd_write, 16'h1000, 4'hf, 32'hffff_ffff);
    access(cmd_read,  16'h1000, 4'hf, 32'd0);
    access(cmd_write, 16'h1008, 4'hf, 32'h0000_0055);
    access(cmd_read,  16'h1008, 4'hf, 32'd0);

    // unmapped accesses where word 0 must survive the write just past memory
    access(cmd_read,  16'h2000, 4'hf, 32'd0);
    access(cmd_write, 16'h0400, 4'hf, 32'hcafe_f00d);
    access(cmd_read,  16'h1010, 4'hf, 32'd0);
    access(cmd_read,  16'h0000, 4'hf, 32'd0);

    // alternate regions on consecutive transfers
    access(cmd_read,  16'h0004, 4'hf, 32'd0);
    access(cmd_read,  16'h1004, 4'hf, 32'd0);
    dat = $random(seed);
    access(cmd_write, 16'h0008, 4'hf, dat);
    access(cmd_read,  16'h100c, 4'hf, 32'd0);
    access(cmd_read,  16'hfff0, 4'hf, 32'd0);
    access(cmd_read,  16'h0008, 4'hf, 32'd0);

    // let the last response be checked
    idle(3);
    if (UUT.u_chk.errors == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "bound checker reported a failing assertion");
    end
  end

endmodule

// File: compile.f
+incdir+design
design/tcb_pkg.sv
design/tcb_map_pkg.sv
design/tcb_decoder.sv
design/tcb_demultiplexer.sv
design/tcb_sram.sv
design/tcb_regs.sv
design/tcb_subsystem.sv
tests/tcb_subsystem_asserts.sv
tests/tcb_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tcb_subsystem_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
